// ==== Makefile ====
TOP := armFetchTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

// ==== tb.f ====
verilog/armIsaPkg.sv
verilog/fetchCfgPkg.sv
verilog/instructionMemory.sv
verilog/instructionDecoder.sv
verilog/branchUnit.sv
verilog/fetchControl.sv
verilog/armFetchTop.sv
verification/armFetchTb.sv

// ==== verification/armFetchTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module armFetchTb;
    import armIsaPkg::*;
    import fetchCfgPkg::*;

    // One program word and what the front end should make of it
    typedef struct {
        instrWordT  word;
        flagsT      flags;
        instrClassT cls;
        condT       cond;
        regIdxT     rd;
        regIdxT     rn;
        regIdxT     rm;
        logic       taken;
        pcT         nextPc;
    } rowT;

    logic       clk;
    logic       rstN;
    logic       wbCyc;
    logic       wbStb;
    logic       wbWe;
    wbAddrT     wbAdr;
    instrWordT  wbDatW;
    instrWordT  wbDatR;
    logic       wbAck;
    logic       decValid;
    logic       decReady;
    pcT         decPc;
    instrWordT  decWord;
    instrClassT decClass;
    condT       decCond;
    regIdxT     decRd;
    regIdxT     decRn;
    regIdxT     decRm;
    logic       decTaken;
    flagsT      flags;

    rowT  rows[$];
    rowT  expItems[$];
    pcT   expPcs[$];
    rowT  monItem;
    pcT   monPc;
    logic randomReady;
    int   errorCount;
    int   passCount;
    int   failCount;
    int   watchdogCycles;

    armFetchTop #(
        .TEST (2)
    ) u_armFetchTop (
        .clk      (clk),
        .rstN     (rstN),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbWe     (wbWe),
        .wbAdr    (wbAdr),
        .wbDatW   (wbDatW),
        .wbDatR   (wbDatR),
        .wbAck    (wbAck),
        .decValid (decValid),
        .decReady (decReady),
        .decPc    (decPc),
        .decWord  (decWord),
        .decClass (decClass),
        .decCond  (decCond),
        .decRd    (decRd),
        .decRn    (decRn),
        .decRm    (decRm),
        .decTaken (decTaken),
        .flags    (flags)
    );

    // 8 ns period
    always #4 clk = ~clk;

    always @(posedge clk) begin
        #1;
        if (randomReady) begin
            decReady = ($urandom % 2) == 0;
        end else begin
            decReady = 1'b1;
        end
    end

    ////////////////////////////////
    // Helpers
    ////////////////////////////////

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, expected);
            errorCount++;
        end
    endtask

    function automatic wbAddrT byteAddr(input logic [7:0] wordIdx);
        return {wordIdx, 2'b00};
    endfunction

    task automatic wbAccess(input logic we, input wbAddrT adr, input instrWordT wdata,
                            output instrWordT rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = we;
        wbAdr  = adr;
        wbDatW = wdata;
        @(posedge clk);
        #1;
        while (!wbAck && waited < 16) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!wbAck) begin
            $display("No Wishbone acknowledge for address 0x%h", adr);
            errorCount++;
        end
        rdata = wbDatR;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
    endtask

    task automatic wbWrite(input wbAddrT adr, input instrWordT data);
        instrWordT ignored;
        wbAccess(1'b1, adr, data, ignored);
    endtask

    task automatic wbRead(input wbAddrT adr, output instrWordT data);
        wbAccess(1'b0, adr, '0, data);
    endtask

    task automatic addRow(input instrWordT word, input flagsT fl, input instrClassT cls,
                          input condT cond, input regIdxT rd, input regIdxT rn,
                          input regIdxT rm, input logic taken, input pcT nextPc);
        rowT r;
        r.word   = word;
        r.flags  = fl;
        r.cls    = cls;
        r.cond   = cond;
        r.rd     = rd;
        r.rn     = rn;
        r.rm     = rm;
        r.taken  = taken;
        r.nextPc = nextPc;
        rows.push_back(r);
    endtask

    task automatic finishTest(input string name, input int errBefore);
        if (errorCount == errBefore) begin
            passCount++;
            $display("[PASS] %s", name);
        end else begin
            failCount++;
            $display("[FAIL] %s (%0d errors)", name, errorCount - errBefore);
        end
    endtask

    ////////////////////////////////
    // Stimulus table
    ////////////////////////////////

    task automatic buildTable();
        // Rows 0..6 hold data processing, multiply, load/store and one coprocessor word
        addRow(32'hE0812003, 4'b0000, classDataProc,  4'hE, 4'd2, 4'd1, 4'd3, 1'b0, 32'd4);
        addRow(32'hE0030291, 4'b0000, classMultiply,  4'hE, 4'd3, 4'd0, 4'd1, 1'b0, 32'd8);
        addRow(32'hE5912004, 4'b0000, classLoadStore, 4'hE, 4'd2, 4'd1, 4'd4, 1'b0, 32'd12);
        addRow(32'h10454006, 4'b0000, classDataProc,  4'h1, 4'd4, 4'd5, 4'd6, 1'b0, 32'd16);
        addRow(32'hE0254796, 4'b0000, classMultiply,  4'hE, 4'd5, 4'd4, 4'd6, 1'b0, 32'd20);
        addRow(32'hE7D10002, 4'b0000, classLoadStore, 4'hE, 4'd0, 4'd1, 4'd2, 1'b0, 32'd24);
        addRow(32'hEE312A01, 4'b0000, classOther,     4'hE, 4'd0, 4'd0, 4'd0, 1'b0, 32'd28);
        // Rows 7..13 run BEQ, BCS and BLT with Z set
        addRow(32'h0A000000, 4'b0100, classBranch,    4'h0, 4'd0, 4'd0, 4'd0, 1'b1, 32'd8);
        addRow(32'hE1A01002, 4'b0100, classDataProc,  4'hE, 4'd1, 4'd0, 4'd2, 1'b0, 32'd8);
        addRow(32'h2A000001, 4'b0100, classBranch,    4'h2, 4'd0, 4'd0, 4'd0, 1'b0, 32'd12);
        addRow(32'hE3A03005, 4'b0100, classDataProc,  4'hE, 4'd3, 4'd0, 4'd5, 1'b0, 32'd16);
        addRow(32'hE1530004, 4'b0100, classDataProc,  4'hE, 4'd0, 4'd3, 4'd4, 1'b0, 32'd20);
        addRow(32'hBA000000, 4'b0100, classBranch,    4'hB, 4'd0, 4'd0, 4'd0, 1'b0, 32'd24);
        addRow(32'hE0812003, 4'b0100, classDataProc,  4'hE, 4'd2, 4'd1, 4'd3, 1'b0, 32'd28);
        // Rows 14..20 repeat the program with N and C set
        addRow(32'h0A000000, 4'b1010, classBranch,    4'h0, 4'd0, 4'd0, 4'd0, 1'b0, 32'd4);
        addRow(32'hE1A01002, 4'b1010, classDataProc,  4'hE, 4'd1, 4'd0, 4'd2, 1'b0, 32'd8);
        addRow(32'h2A000001, 4'b1010, classBranch,    4'h2, 4'd0, 4'd0, 4'd0, 1'b1, 32'd20);
        addRow(32'hE3A03005, 4'b1010, classDataProc,  4'hE, 4'd3, 4'd0, 4'd5, 1'b0, 32'd16);
        addRow(32'hE1530004, 4'b1010, classDataProc,  4'hE, 4'd0, 4'd3, 4'd4, 1'b0, 32'd20);
        addRow(32'hBA000000, 4'b1010, classBranch,    4'hB, 4'd0, 4'd0, 4'd0, 1'b1, 32'd28);
        addRow(32'hE0812003, 4'b1010, classDataProc,  4'hE, 4'd2, 4'd1, 4'd3, 1'b0, 32'd28);
        // Rows 21..27 with all flags clear and nothing taken
        addRow(32'h0A000000, 4'b0000, classBranch,    4'h0, 4'd0, 4'd0, 4'd0, 1'b0, 32'd4);
        addRow(32'hE1A01002, 4'b0000, classDataProc,  4'hE, 4'd1, 4'd0, 4'd2, 1'b0, 32'd8);
        addRow(32'h2A000001, 4'b0000, classBranch,    4'h2, 4'd0, 4'd0, 4'd0, 1'b0, 32'd12);
        addRow(32'hE3A03005, 4'b0000, classDataProc,  4'hE, 4'd3, 4'd0, 4'd5, 1'b0, 32'd16);
        addRow(32'hE1530004, 4'b0000, classDataProc,  4'hE, 4'd0, 4'd3, 4'd4, 1'b0, 32'd20);
        addRow(32'hBA000000, 4'b0000, classBranch,    4'hB, 4'd0, 4'd0, 4'd0, 1'b0, 32'd24);
        addRow(32'hE0812003, 4'b0000, classDataProc,  4'hE, 4'd2, 4'd1, 4'd3, 1'b0, 32'd28);
    endtask

    // Loads rows first..first+count-1 at address 0 and closes with a branch to itself
    task automatic runProgram(input string name, input int first, input int count,
                              input logic randomStall);
        int        errBefore;
        int        steps;
        int        waited;
        int        rowIdx;
        pcT        pc;
        rowT       selfBranch;
        instrWordT data;
        errBefore = errorCount;
        wbWrite(byteAddr(ctrlAddr), 32'd0);
        for (int i = 0; i < count; i++) begin
            wbWrite(byteAddr(8'(i)), rows[first + i].word);
        end
        selfBranch.word   = 32'hEAFFFFFE;
        selfBranch.flags  = '0;
        selfBranch.cls    = classBranch;
        selfBranch.cond   = 4'hE;
        selfBranch.rd     = '0;
        selfBranch.rn     = '0;
        selfBranch.rm     = '0;
        selfBranch.taken  = 1'b1;
        selfBranch.nextPc = pcT'(count * 4);
        wbWrite(byteAddr(8'(count)), selfBranch.word);

        // Walk the expected control flow through the table
        pc = '0;
        steps = 0;
        while (int'(pc) < count * 4 && steps <= count) begin
            rowIdx = first + int'(pc >> 2);
            expItems.push_back(rows[rowIdx]);
            expPcs.push_back(pc);
            pc = rows[rowIdx].nextPc;
            steps++;
        end
        expItems.push_back(selfBranch);
        expPcs.push_back(pcT'(count * 4));

        flags = (count > 0) ? rows[first].flags : 4'h0;
        randomReady = randomStall;
        wbWrite(byteAddr(ctrlAddr), 32'd1);

        waited = 0;
        while (expPcs.size() != 0 && waited < 100 + 20 * count) begin
            @(posedge clk);
            waited++;
        end
        if (expPcs.size() != 0) begin
            $display("%0d expected items never arrived", expPcs.size());
            errorCount++;
            expPcs.delete();
            expItems.delete();
        end

        // Halted status should follow the last transfer
        waited = 0;
        wbRead(byteAddr(ctrlAddr), data);
        while (data != 32'd2 && waited < 10) begin
            wbRead(byteAddr(ctrlAddr), data);
            waited++;
        end
        checkValue("status", data, 32'd2);
        wbRead(byteAddr(pcAddr), data);
        checkValue("pc", data, pcT'(count * 4));
        repeat (20) @(posedge clk);
        checkValue("decValid", 32'(decValid), 32'd0);
        randomReady = 1'b0;
        finishTest(name, errBefore);
    endtask

    ////////////////////////////////
    // Stream monitor
    ////////////////////////////////

    always @(negedge clk) begin
        if (rstN && decValid && decReady) begin
            if (expPcs.size() == 0) begin
                $display("Unexpected item at address 0x%h with nothing left to expect", decPc);
                errorCount++;
            end else begin
                monItem = expItems.pop_front();
                monPc   = expPcs.pop_front();
                checkValue("decPc", decPc, monPc);
                checkValue("decWord", decWord, monItem.word);
                checkValue("decClass", 32'(decClass), 32'(monItem.cls));
                checkValue("decCond", 32'(decCond), 32'(monItem.cond));
                checkValue("decRd", 32'(decRd), 32'(monItem.rd));
                checkValue("decRn", 32'(decRn), 32'(monItem.rn));
                checkValue("decRm", 32'(decRm), 32'(monItem.rm));
                checkValue("decTaken", 32'(decTaken), 32'(monItem.taken));
            end
        end
    end

    initial begin
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles", watchdogCycles);
        $display("Testbench failed");
        $finish;
    end

    ////////////////////////////////
    // Main sequence
    ////////////////////////////////

    initial begin
        instrWordT data;
        wordAddrT  hostIdx [8];
        instrWordT hostData [8];
        int        errBefore;
        void'($urandom(3670));
        clk         = 1'b0;
        rstN        = 1'b0;
        wbCyc       = 1'b0;
        wbStb       = 1'b0;
        wbWe        = 1'b0;
        wbAdr       = '0;
        wbDatW      = '0;
        decReady    = 1'b0;
        flags       = '0;
        randomReady = 1'b0;
        errorCount  = 0;
        passCount   = 0;
        failCount   = 0;
        buildTable();
        watchdogCycles = 200 * rows.size() + 2000;
        repeat (10) @(posedge clk);
        #1;
        rstN = 1'b1;

        errBefore = errorCount;
        checkValue("decValid", 32'(decValid), 32'd0);
        checkValue("wbAck", 32'(wbAck), 32'd0);
        wbRead(byteAddr(ctrlAddr), data);
        checkValue("status", data, 32'd0);
        wbRead(byteAddr(pcAddr), data);
        checkValue("pc", data, 32'd0);
        wbRead(byteAddr(8'd0), data);
        checkValue("mem[0]", data, 32'hE59F1208);
        finishTest("reset state and preload", errBefore);

        // One random word per 16-word slice, so no two collide
        errBefore = errorCount;
        for (int i = 0; i < 8; i++) begin
            hostIdx[i]  = wordAddrT'(i * 16 + int'($urandom % 16));
            hostData[i] = $urandom;
            wbWrite(byteAddr({1'b0, hostIdx[i]}), hostData[i]);
        end
        for (int i = 0; i < 8; i++) begin
            wbRead(byteAddr({1'b0, hostIdx[i]}), data);
            checkValue("wbDatR", data, hostData[i]);
        end
        // Word 130 must not alias onto memory word 2
        wbWrite(byteAddr(8'd2), 32'h13579BDF);
        wbWrite(byteAddr(8'd130), 32'hA5A55A5A);
        wbRead(byteAddr(8'd130), data);
        checkValue("wbDatR", data, 32'd0);
        wbRead(byteAddr(8'd2), data);
        checkValue("wbDatR", data, 32'h13579BDF);
        finishTest("host port", errBefore);

        runProgram("sequential decode", 0, 7, 1'b0);
        runProgram("branches with Z set", 7, 7, 1'b0);
        runProgram("branches with N and C set", 14, 7, 1'b0);
        runProgram("branches with flags clear", 21, 7, 1'b0);
        runProgram("back-pressure", 0, 7, 1'b1);
        runProgram("halt on branch to itself", 0, 0, 1'b0);

        $display("Tests: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/armFetchTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module armFetchTop #(
    parameter int TEST = 0
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  wbCyc,
    input  logic                  wbStb,
    input  logic                  wbWe,
    input  fetchCfgPkg::wbAddrT   wbAdr,
    input  armIsaPkg::instrWordT  wbDatW,
    output armIsaPkg::instrWordT  wbDatR,
    output logic                  wbAck,
    output logic                  decValid,
    input  logic                  decReady,
    output fetchCfgPkg::pcT       decPc,
    output armIsaPkg::instrWordT  decWord,
    output armIsaPkg::instrClassT decClass,
    output armIsaPkg::condT       decCond,
    output armIsaPkg::regIdxT     decRd,
    output armIsaPkg::regIdxT     decRn,
    output armIsaPkg::regIdxT     decRm,
    output logic                  decTaken,
    input  armIsaPkg::flagsT      flags
);
    import armIsaPkg::*;
    import fetchCfgPkg::*;

    logic       memWrEn;
    wordAddrT   memAddr;
    instrWordT  memWrData;
    instrWordT  memRdData;
    pcT         fetchPc;
    instrWordT  fetchWord;
    condT       cond;
    instrClassT iClass;
    regIdxT     rd;
    regIdxT     rn;
    regIdxT     rm;
    logic       taken;
    pcT         target;
    logic       selfLoop;

    fetchControl u_fetchControl (
        .clk       (clk),
        .rstN      (rstN),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDatW    (wbDatW),
        .wbDatR    (wbDatR),
        .wbAck     (wbAck),
        .memWrEn   (memWrEn),
        .memAddr   (memAddr),
        .memWrData (memWrData),
        .memRdData (memRdData),
        .fetchPc   (fetchPc),
        .fetchWord (fetchWord),
        .cond      (cond),
        .iClass    (iClass),
        .rd        (rd),
        .rn        (rn),
        .rm        (rm),
        .taken     (taken),
        .target    (target),
        .selfLoop  (selfLoop),
        .decValid  (decValid),
        .decReady  (decReady),
        .decPc     (decPc),
        .decWord   (decWord),
        .decClass  (decClass),
        .decCond   (decCond),
        .decRd     (decRd),
        .decRn     (decRn),
        .decRm     (decRm),
        .decTaken  (decTaken)
    );

    // Host port and fetch port share the array
    instructionMemory #(
        .TEST (TEST)
    ) u_instructionMemory (
        .clk       (clk),
        .wrEn      (memWrEn),
        .wrAddr    (memAddr),
        .wrData    (memWrData),
        .rdAddr    (memAddr),
        .rdData    (memRdData),
        .fetchPc   (fetchPc),
        .fetchWord (fetchWord)
    );

    instructionDecoder u_instructionDecoder (
        .word   (fetchWord),
        .cond   (cond),
        .iClass (iClass),
        .rd     (rd),
        .rn     (rn),
        .rm     (rm)
    );

    branchUnit u_branchUnit (
        .word     (fetchWord),
        .iClass   (iClass),
        .flags    (flags),
        .pc       (fetchPc),
        .taken    (taken),
        .target   (target),
        .selfLoop (selfLoop)
    );

endmodule

`default_nettype wire

// ==== verilog/armIsaPkg.sv ====
`default_nettype none

package armIsaPkg;

    ////////////////////////////////
    // Instruction word fields
    ////////////////////////////////

    typedef logic [31:0] instrWordT;
    typedef logic [3:0]  condT;
    typedef logic [3:0]  regIdxT;

    // N Z C V from the msb down
    typedef logic [3:0]  flagsT;

    // Condition field encodings
    localparam condT condEq = 4'h0;
    localparam condT condNe = 4'h1;
    localparam condT condCs = 4'h2;
    localparam condT condCc = 4'h3;
    localparam condT condMi = 4'h4;
    localparam condT condPl = 4'h5;
    localparam condT condVs = 4'h6;
    localparam condT condVc = 4'h7;
    localparam condT condHi = 4'h8;
    localparam condT condLs = 4'h9;
    localparam condT condGe = 4'hA;
    localparam condT condLt = 4'hB;
    localparam condT condGt = 4'hC;
    localparam condT condLe = 4'hD;
    localparam condT condAl = 4'hE;

    // Coarse instruction classes seen by the front end
    typedef enum logic [2:0] {
        classDataProc,
        classMultiply,
        classLoadStore,
        classBranch,
        classOther
    } instrClassT;

endpackage

`default_nettype wire

// ==== verilog/branchUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module branchUnit (
    input  armIsaPkg::instrWordT  word,
    input  armIsaPkg::instrClassT iClass,
    input  armIsaPkg::flagsT      flags,
    input  fetchCfgPkg::pcT       pc,
    output logic                  taken,
    output fetchCfgPkg::pcT       target,
    output logic                  selfLoop
);
    import armIsaPkg::*;
    import fetchCfgPkg::*;

    logic n;
    logic z;
    logic c;
    logic v;
    logic condPass;
    pcT   offset;

    assign {n, z, c, v} = flags;

    always_comb begin
        case (word[31:28])
            condEq:  condPass = z;
            condNe:  condPass = !z;
            condCs:  condPass = c;
            condCc:  condPass = !c;
            condMi:  condPass = n;
            condPl:  condPass = !n;
            condVs:  condPass = v;
            condVc:  condPass = !v;
            condHi:  condPass = c && !z;
            condLs:  condPass = !c || z;
            condGe:  condPass = (n == v);
            condLt:  condPass = (n != v);
            condGt:  condPass = !z && (n == v);
            condLe:  condPass = z || (n != v);
            condAl:  condPass = 1'b1;
            // 1111 never executes here
            default: condPass = 1'b0;
        endcase
    end

    // Sign-extended word offset
    assign offset = {{6{word[23]}}, word[23:0], 2'b00};

    assign taken    = condPass && (iClass == classBranch);
    assign target   = pc + 32'd8 + offset;
    assign selfLoop = taken && (target == pc);

endmodule

`default_nettype wire

// ==== verilog/fetchCfgPkg.sv ====
`default_nettype none

package fetchCfgPkg;

    ////////////////////////////////
    // Memory geometry
    ////////////////////////////////

    localparam int memDepth = 128;

    typedef logic [6:0]  wordAddrT;
    typedef logic [31:0] pcT;

    // Address of the last word in memory
    localparam pcT lastPc = pcT'((memDepth - 1) * 4);

    ////////////////////////////////
    // Host register map
    ////////////////////////////////

    typedef logic [9:0] wbAddrT;

    // Word indices above the memory window
    localparam logic [7:0] ctrlAddr = 8'd128;
    localparam logic [7:0] pcAddr   = 8'd129;

    typedef enum logic [1:0] {
        stIdle,
        stRun,
        stHalt
    } fetchStateT;

endpackage

`default_nettype wire

// ==== verilog/fetchControl.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetchControl (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  wbCyc,
    input  logic                  wbStb,
    input  logic                  wbWe,
    input  fetchCfgPkg::wbAddrT   wbAdr,
    input  armIsaPkg::instrWordT  wbDatW,
    output armIsaPkg::instrWordT  wbDatR,
    output logic                  wbAck,
    output logic                  memWrEn,
    output fetchCfgPkg::wordAddrT memAddr,
    output armIsaPkg::instrWordT  memWrData,
    input  armIsaPkg::instrWordT  memRdData,
    output fetchCfgPkg::pcT       fetchPc,
    input  armIsaPkg::instrWordT  fetchWord,
    input  armIsaPkg::condT       cond,
    input  armIsaPkg::instrClassT iClass,
    input  armIsaPkg::regIdxT     rd,
    input  armIsaPkg::regIdxT     rn,
    input  armIsaPkg::regIdxT     rm,
    input  logic                  taken,
    input  fetchCfgPkg::pcT       target,
    input  logic                  selfLoop,
    output logic                  decValid,
    input  logic                  decReady,
    output fetchCfgPkg::pcT       decPc,
    output armIsaPkg::instrWordT  decWord,
    output armIsaPkg::instrClassT decClass,
    output armIsaPkg::condT       decCond,
    output armIsaPkg::regIdxT     decRd,
    output armIsaPkg::regIdxT     decRn,
    output armIsaPkg::regIdxT     decRm,
    output logic                  decTaken
);
    import armIsaPkg::*;
    import fetchCfgPkg::*;

    fetchStateT state;
    pcT         pc;
    logic [7:0] wbWord;
    logic       wbReq;
    logic       ctrlWr;
    logic       xfer;
    logic       advance;
    logic       decStop;
    instrWordT  readValue;

    ////////////////////////////////
    // Wishbone slave
    ////////////////////////////////

    // One request per held cycle; the ack cycle is not a new request
    assign wbReq     = wbCyc && wbStb && !wbAck;
    assign wbWord    = wbAdr[9:2];
    assign memAddr   = wbWord[6:0];
    assign memWrEn   = wbReq && wbWe && !wbWord[7];
    assign memWrData = wbDatW;
    assign ctrlWr    = wbReq && wbWe && (wbWord == ctrlAddr);

    always_comb begin
        if (!wbWord[7]) begin
            readValue = memRdData;
        end else if (wbWord == ctrlAddr) begin
            readValue = {30'd0, state == stHalt, state == stRun};
        end else if (wbWord == pcAddr) begin
            readValue = pc;
        end else begin
            readValue = '0;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbAck <= 1'b0;
        end else begin
            wbAck <= wbReq;
        end
    end

    always_ff @(posedge clk) begin
        if (wbReq && !wbWe) begin
            wbDatR <= readValue;
        end
    end

    ////////////////////////////////
    // Fetch FSM and PC
    ////////////////////////////////

    assign xfer    = decValid && decReady;
    // Load when the slot is free, never past a stopping item
    assign advance = (state == stRun) && !ctrlWr && (!decValid || (decReady && !decStop));
    assign fetchPc = pc;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= stIdle;
            pc    <= '0;
        end else if (ctrlWr) begin
            if (wbDatW[0]) begin
                state <= stRun;
                pc    <= '0;
            end else begin
                state <= stIdle;
            end
        end else begin
            if (xfer && decStop && (state == stRun)) begin
                state <= stHalt;
            end
            if (advance) begin
                pc <= taken ? target : pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decValid <= 1'b0;
        end else if (advance) begin
            decValid <= 1'b1;
        end else if (xfer) begin
            decValid <= 1'b0;
        end
    end

    // Output item register
    always_ff @(posedge clk) begin
        if (advance) begin
            decPc    <= pc;
            decWord  <= fetchWord;
            decClass <= iClass;
            decCond  <= cond;
            decRd    <= rd;
            decRn    <= rn;
            decRm    <= rm;
            decTaken <= taken;
            decStop  <= selfLoop || (pc == lastPc);
        end
    end

    wbAckSingle: assert property (@(posedge clk) disable iff (!rstN) wbAck |=> !wbAck);

    streamHold: assert property (@(posedge clk) disable iff (!rstN)
        decValid && !decReady |=> decValid && $stable(decPc) && $stable(decWord)
            && $stable(decClass) && $stable(decCond) && $stable(decRd)
            && $stable(decRn) && $stable(decRm) && $stable(decTaken));

endmodule

`default_nettype wire

// ==== verilog/instructionDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module instructionDecoder (
    input  armIsaPkg::instrWordT  word,
    output armIsaPkg::condT       cond,
    output armIsaPkg::instrClassT iClass,
    output armIsaPkg::regIdxT     rd,
    output armIsaPkg::regIdxT     rn,
    output armIsaPkg::regIdxT     rm
);
    import armIsaPkg::*;

    logic isMultiply;

    assign cond = word[31:28];

    // Multiply shares the 00 group with data processing
    assign isMultiply = (word[27:22] == 6'b000000) && (word[7:4] == 4'b1001);

    ////////////////////////////////
    // Class
    ////////////////////////////////

    always_comb begin
        if (word[27:25] == 3'b101) begin
            iClass = classBranch;
        end else if (word[27:26] == 2'b01) begin
            iClass = classLoadStore;
        end else if (isMultiply) begin
            iClass = classMultiply;
        end else if (word[27:26] == 2'b00) begin
            iClass = classDataProc;
        end else begin
            // coprocessor and the rest land here
            iClass = classOther;
        end
    end

    ////////////////////////////////
    // Register fields
    ////////////////////////////////

    always_comb begin
        rd = '0;
        rn = '0;
        rm = '0;
        case (iClass)
            classDataProc, classLoadStore: begin
                rd = word[15:12];
                rn = word[19:16];
                rm = word[3:0];
            end
            classMultiply: begin
                // Destination sits in the Rn slot
                rd = word[19:16];
                rn = word[15:12];
                rm = word[3:0];
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/instructionMemory.sv ====
`timescale 1ns/100ps
`default_nettype none

module instructionMemory #(
    parameter int TEST = 0
) (
    input  logic                  clk,
    input  logic                  wrEn,
    input  fetchCfgPkg::wordAddrT wrAddr,
    input  armIsaPkg::instrWordT  wrData,
    input  fetchCfgPkg::wordAddrT rdAddr,
    output armIsaPkg::instrWordT  rdData,
    input  fetchCfgPkg::pcT       fetchPc,
    output armIsaPkg::instrWordT  fetchWord
);
    import armIsaPkg::*;
    import fetchCfgPkg::*;

    instrWordT mem [0:memDepth-1];

    // Built-in programs
    initial begin
        for (int i = 0; i < memDepth; i++) begin
            mem[i] = '0;
        end
        case (TEST)
            0: begin
                // Data processing sample
                mem[0] = 32'hE0812003;
                mem[1] = 32'hE0423001;
                mem[2] = 32'hE1A04002;
                mem[3] = 32'hE0035004;
                mem[4] = 32'hE1856003;
                mem[5] = 32'hE3A07011;
                mem[6] = 32'hE1550006;
            end
            1: begin
                // Count to eight, then spin
                mem[0] = 32'hE3A00000;
                mem[1] = 32'hE2800001;
                mem[2] = 32'hE3500008;
                mem[3] = 32'h1AFFFFFC;
                mem[4] = 32'hEAFFFFFE;
            end
            2: begin
                mem[0] = 32'hE59F1208;
                mem[1] = 32'hEE312A01;
                mem[2] = 32'hEAFFFFFE;
            end
            default: begin
            end
        endcase
    end

    always @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    assign rdData    = mem[rdAddr];
    // Low two bits dropped for the word index
    assign fetchWord = mem[fetchPc[8:2]];

    fetchAligned: assert property (@(posedge clk) fetchPc[1:0] == 2'b00);

endmodule

`default_nettype wire
